//--- Bender.yml
package:
  name: cpu_pipe

sources:
  - files:
      - logic/cpu_pkg.sv
      - logic/cpu_ifs.sv
      - logic/fetch_stage.sv
      - logic/decode_stage.sv
      - logic/execute_stage.sv
      - logic/memory_stage.sv
      - logic/cpu_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/cpu_tb.sv

//--- flist.f
+incdir+tb
logic/cpu_pkg.sv
logic/cpu_ifs.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/cpu_top.sv
tb/cpu_tb.sv

//--- logic/cpu_ifs.sv
`timescale 1ns/100ps

// stall, flush and redirect between fetch, decode and execute
interface hazard_if;
   logic                       stall;
   logic                       flush;
   logic [cpu_pkg::WORD_W-1:0] redirect_pc;
   logic [cpu_pkg::REG_AW-1:0] ex_load_dst;
   logic                       ex_is_load;

   modport fetch_mp (
      input stall,
      input flush,
      input redirect_pc
   );

   modport decode_mp (
      output stall,
      input  flush,
      input  ex_load_dst,
      input  ex_is_load
   );

   modport execute_mp (
      output flush,
      output redirect_pc,
      output ex_load_dst,
      output ex_is_load
   );
endinterface

// forwarding taps from ex/mem and the write-back port
interface result_if;
   logic                       mem_we;
   logic [cpu_pkg::REG_AW-1:0] mem_dst;
   logic [cpu_pkg::WORD_W-1:0] mem_data;
   logic                       wb_we;
   logic [cpu_pkg::REG_AW-1:0] wb_dst;
   logic [cpu_pkg::WORD_W-1:0] wb_data;

   modport source_mp (
      output mem_we, mem_dst, mem_data,
      output wb_we, wb_dst, wb_data
   );

   modport execute_mp (
      input mem_we, mem_dst, mem_data,
      input wb_we, wb_dst, wb_data
   );

   modport regfile_mp (
      input wb_we, wb_dst, wb_data
   );
endinterface

//--- logic/cpu_pkg.sv
package cpu_pkg;

   localparam int WORD_W = 16;
   localparam int REG_AW = 3;

   // top field of the instruction, codes 11 to 15 are illegal
   typedef enum logic [3:0] {
      OP_HALT = 4'd0,
      OP_NOP  = 4'd1,
      OP_ADD  = 4'd2,
      OP_SUB  = 4'd3,
      OP_AND  = 4'd4,
      OP_XOR  = 4'd5,
      OP_ADDI = 4'd6,
      OP_LBI  = 4'd7,
      OP_LD   = 4'd8,
      OP_ST   = 4'd9,
      OP_BEQZ = 4'd10
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR,
      ALU_PASS_B
   } alu_op_e;

   // per-instruction control, all zero is a nop
   typedef struct packed {
      alu_op_e alu_op;
      logic    use_imm;
      logic    reg_we;
      logic    mem_rd;
      logic    mem_wr;
      logic    is_branch;
      logic    is_halt;
   } ctrl_t;

   typedef struct packed {
      logic              valid;
      logic [WORD_W-1:0] pc;
      logic [WORD_W-1:0] instr;
   } if_id_t;

   typedef struct packed {
      logic              valid;
      ctrl_t             ctrl;
      logic [WORD_W-1:0] pc;
      logic [REG_AW-1:0] rs;
      logic [REG_AW-1:0] rt;
      logic [REG_AW-1:0] dst;
      logic [WORD_W-1:0] op_a;
      logic [WORD_W-1:0] op_b;
      logic [WORD_W-1:0] imm;
      logic [REG_AW-1:0] st_reg;
   } id_ex_t;

   typedef struct packed {
      logic              valid;
      ctrl_t             ctrl;
      logic [REG_AW-1:0] dst;
      logic [WORD_W-1:0] alu_result;
      logic [WORD_W-1:0] store_data;
   } ex_mem_t;

   typedef struct packed {
      logic              valid;
      logic              reg_we;
      logic [REG_AW-1:0] dst;
      logic [WORD_W-1:0] wb_data;
   } mem_wb_t;

endpackage

//--- logic/cpu_top.sv
`timescale 1ns/100ps

module cpu_top #(
   parameter int IMEM_WORDS = 256,
   parameter int DMEM_WORDS = 256
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          imem_we,
   input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
   input  logic [cpu_pkg::WORD_W-1:0]    imem_wdata,
   input  logic [cpu_pkg::REG_AW-1:0]    dbg_addr,
   output logic [cpu_pkg::WORD_W-1:0]    dbg_data,
   output logic                          st_valid,
   output logic [cpu_pkg::WORD_W-1:0]    st_addr,
   output logic [cpu_pkg::WORD_W-1:0]    st_data,
   output logic                          halted,
   output logic                          err
);

   cpu_pkg::if_id_t  if_id;
   cpu_pkg::id_ex_t  id_ex;
   cpu_pkg::ex_mem_t ex_mem;

   hazard_if hz_if ();
   result_if res_if ();

   fetch_stage #(
      .IMEM_WORDS (IMEM_WORDS)
   ) u_fetch (
      .clk        (clk),
      .arst_n     (arst_n),
      .imem_we    (imem_we),
      .imem_addr  (imem_addr),
      .imem_wdata (imem_wdata),
      .halted     (halted),
      .hz         (hz_if.fetch_mp),
      .if_id      (if_id)
   );

   decode_stage u_decode (
      .clk      (clk),
      .arst_n   (arst_n),
      .halted   (halted),
      .if_id    (if_id),
      .hz       (hz_if.decode_mp),
      .res      (res_if.regfile_mp),
      .dbg_addr (dbg_addr),
      .dbg_data (dbg_data),
      .id_ex    (id_ex),
      .err      (err)
   );

   execute_stage u_execute (
      .clk    (clk),
      .arst_n (arst_n),
      .halted (halted),
      .id_ex  (id_ex),
      .hz     (hz_if.execute_mp),
      .res    (res_if.execute_mp),
      .ex_mem (ex_mem)
   );

   memory_stage #(
      .DMEM_WORDS (DMEM_WORDS)
   ) u_memory (
      .clk      (clk),
      .arst_n   (arst_n),
      .ex_mem   (ex_mem),
      .res      (res_if.source_mp),
      .st_valid (st_valid),
      .st_addr  (st_addr),
      .st_data  (st_data),
      .halted   (halted)
   );

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       halted,
   input  cpu_pkg::if_id_t            if_id,
   hazard_if.decode_mp                hz,
   result_if.regfile_mp               res,
   input  logic [cpu_pkg::REG_AW-1:0] dbg_addr,
   output logic [cpu_pkg::WORD_W-1:0] dbg_data,
   output cpu_pkg::id_ex_t            id_ex,
   output logic                       err
);

   localparam int W     = cpu_pkg::WORD_W;
   localparam int NREGS = 2 ** cpu_pkg::REG_AW;

   logic [W-1:0]               rf [1:NREGS-1];
   logic [W-1:0]               rf_view [NREGS];
   cpu_pkg::opcode_e           op;
   cpu_pkg::ctrl_t             ctrl;
   logic [cpu_pkg::REG_AW-1:0] rd, rs, rt, rb;
   logic [W-1:0]               imm;
   logic                       illegal;
   logic                       use_a, use_b;
   logic                       halt_seen;
   logic                       take;

   assign op = cpu_pkg::opcode_e'(if_id.instr[15:12]);
   assign rd = if_id.instr[11:9];
   assign rs = if_id.instr[8:6];
   assign rt = if_id.instr[5:3];

   always_comb begin
      ctrl        = '0;
      ctrl.alu_op = cpu_pkg::ALU_ADD;
      illegal     = 1'b0;
      use_a       = 1'b0;
      use_b       = 1'b0;
      imm         = {{(W-6){if_id.instr[5]}}, if_id.instr[5:0]};
      case (op)
         cpu_pkg::OP_HALT: ctrl.is_halt = 1'b1;
         cpu_pkg::OP_NOP: ;
         cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_XOR: begin
            ctrl.reg_we = 1'b1;
            use_a       = 1'b1;
            use_b       = 1'b1;
            if (op == cpu_pkg::OP_SUB) ctrl.alu_op = cpu_pkg::ALU_SUB;
            if (op == cpu_pkg::OP_AND) ctrl.alu_op = cpu_pkg::ALU_AND;
            if (op == cpu_pkg::OP_XOR) ctrl.alu_op = cpu_pkg::ALU_XOR;
         end
         cpu_pkg::OP_ADDI: begin
            ctrl.use_imm = 1'b1;
            ctrl.reg_we  = 1'b1;
            use_a        = 1'b1;
         end
         cpu_pkg::OP_LBI: begin
            ctrl.alu_op  = cpu_pkg::ALU_PASS_B;
            ctrl.use_imm = 1'b1;
            ctrl.reg_we  = 1'b1;
            imm          = {{(W-9){if_id.instr[8]}}, if_id.instr[8:0]};
         end
         cpu_pkg::OP_LD: begin
            ctrl.use_imm = 1'b1;
            ctrl.reg_we  = 1'b1;
            ctrl.mem_rd  = 1'b1;
            use_a        = 1'b1;
         end
         cpu_pkg::OP_ST: begin
            ctrl.use_imm = 1'b1;
            ctrl.mem_wr  = 1'b1;
            use_a        = 1'b1;
            use_b        = 1'b1;
         end
         cpu_pkg::OP_BEQZ: begin
            ctrl.is_branch = 1'b1;
            use_a          = 1'b1;
         end
         // unknown codes trap and run as a nop
         default: illegal = 1'b1;
      endcase
   end

   // store data comes from rd on the second read port
   assign rb = ctrl.mem_wr ? rd : rt;

   // r0 is hardwired, a same-cycle write shows through
   always_comb begin
      rf_view[0] = '0;
      for (int i = 1; i < NREGS; i++) begin
         if (res.wb_we && res.wb_dst == cpu_pkg::REG_AW'(i)) rf_view[i] = res.wb_data;
         else rf_view[i] = rf[i];
      end
   end

   assign dbg_data = rf_view[dbg_addr];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 1; i < NREGS; i++) rf[i] <= '0;
      end else if (res.wb_we && res.wb_dst != '0) begin
         rf[res.wb_dst] <= res.wb_data;
      end
   end

   // load in execute feeds this instruction, wait one cycle
   assign hz.stall = if_id.valid && !halt_seen && hz.ex_is_load && hz.ex_load_dst != '0 &&
                     ((use_a && rs == hz.ex_load_dst) || (use_b && rb == hz.ex_load_dst));

   // nothing younger than a halt leaves decode
   assign take = if_id.valid && !halt_seen && !hz.stall && !hz.flush;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         id_ex     <= '0;
         halt_seen <= 1'b0;
         err       <= 1'b0;
      end else if (!halted) begin
         if (take) begin
            id_ex.valid  <= 1'b1;
            id_ex.ctrl   <= ctrl;
            id_ex.pc     <= if_id.pc;
            id_ex.rs     <= rs;
            id_ex.rt     <= rt;
            id_ex.dst    <= rd;
            id_ex.op_a   <= rf_view[rs];
            id_ex.op_b   <= rf_view[rb];
            id_ex.imm    <= imm;
            id_ex.st_reg <= rd;
         end else begin
            id_ex <= '0;
         end
         if (take && illegal) err <= 1'b1;
         if (take && ctrl.is_halt) halt_seen <= 1'b1;
      end
   end

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             halted,
   input  cpu_pkg::id_ex_t  id_ex,
   hazard_if.execute_mp     hz,
   result_if.execute_mp     res,
   output cpu_pkg::ex_mem_t ex_mem
);

   localparam int W  = cpu_pkg::WORD_W;
   localparam int AW = cpu_pkg::REG_AW;

   logic [AW-1:0] b_idx;
   logic [W-1:0]  op_a, op_b;
   logic [W-1:0]  alu_b;
   logic [W-1:0]  alu_y;
   logic          taken;

   // ex/mem is younger than mem/wb so it is checked first
   function automatic logic [W-1:0] fwd(
      input logic [AW-1:0] idx,
      input logic [W-1:0]  reg_val,
      input logic          mem_we,
      input logic [AW-1:0] mem_dst,
      input logic [W-1:0]  mem_data,
      input logic          wb_we,
      input logic [AW-1:0] wb_dst,
      input logic [W-1:0]  wb_data
   );
      if (idx == '0) return reg_val;
      if (mem_we && mem_dst == idx) return mem_data;
      if (wb_we && wb_dst == idx) return wb_data;
      return reg_val;
   endfunction

   assign b_idx = id_ex.ctrl.mem_wr ? id_ex.st_reg : id_ex.rt;

   assign op_a = fwd(id_ex.rs, id_ex.op_a, res.mem_we, res.mem_dst, res.mem_data,
                     res.wb_we, res.wb_dst, res.wb_data);
   assign op_b = fwd(b_idx, id_ex.op_b, res.mem_we, res.mem_dst, res.mem_data,
                     res.wb_we, res.wb_dst, res.wb_data);

   assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : op_b;

   always_comb begin
      case (id_ex.ctrl.alu_op)
         cpu_pkg::ALU_ADD:    alu_y = op_a + alu_b;
         cpu_pkg::ALU_SUB:    alu_y = op_a - alu_b;
         cpu_pkg::ALU_AND:    alu_y = op_a & alu_b;
         cpu_pkg::ALU_XOR:    alu_y = op_a ^ alu_b;
         cpu_pkg::ALU_PASS_B: alu_y = alu_b;
         default:             alu_y = op_a + alu_b;
      endcase
   end

   // beqz resolves here, the two younger slots get flushed
   assign taken          = id_ex.valid && id_ex.ctrl.is_branch && op_a == '0 && !halted;
   assign hz.flush       = taken;
   assign hz.redirect_pc = id_ex.pc + W'(1) + id_ex.imm;
   assign hz.ex_is_load  = id_ex.valid && id_ex.ctrl.mem_rd;
   assign hz.ex_load_dst = id_ex.dst;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ex_mem <= '0;
      end else if (!halted) begin
         ex_mem.valid      <= id_ex.valid;
         ex_mem.ctrl       <= id_ex.ctrl;
         ex_mem.dst        <= id_ex.dst;
         ex_mem.alu_result <= alu_y;
         ex_mem.store_data <= op_b;
      end
   end

endmodule

//--- logic/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage #(
   parameter int IMEM_WORDS = 256
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          imem_we,
   input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
   input  logic [cpu_pkg::WORD_W-1:0]    imem_wdata,
   input  logic                          halted,
   hazard_if.fetch_mp                    hz,
   output cpu_pkg::if_id_t               if_id
);

   localparam int IA_W = $clog2(IMEM_WORDS);

   logic [cpu_pkg::WORD_W-1:0] imem [IMEM_WORDS];
   logic [cpu_pkg::WORD_W-1:0] pc;
   logic [IA_W-1:0]            fetch_idx;

   // program load port, usable while the core sits in reset
   always_ff @(posedge clk) begin
      if (imem_we) begin
         imem[imem_addr] <= imem_wdata;
      end
   end

   // pc wraps onto the memory depth
   assign fetch_idx = pc[IA_W-1:0];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc    <= '0;
         if_id <= '0;
      end else if (!halted) begin
         if (hz.flush) begin
            // taken branch in execute, drop the younger fetch
            pc          <= hz.redirect_pc;
            if_id.valid <= 1'b0;
         end else if (!hz.stall) begin
            pc          <= pc + 1'b1;
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.instr <= imem[fetch_idx];
         end
         // stall holds both pc and if_id
      end
   end

endmodule

//--- logic/memory_stage.sv
`timescale 1ns/100ps

module memory_stage #(
   parameter int DMEM_WORDS = 256
) (
   input  logic                       clk,
   input  logic                       arst_n,
   input  cpu_pkg::ex_mem_t           ex_mem,
   result_if.source_mp                res,
   output logic                       st_valid,
   output logic [cpu_pkg::WORD_W-1:0] st_addr,
   output logic [cpu_pkg::WORD_W-1:0] st_data,
   output logic                       halted
);

   localparam int DA_W = $clog2(DMEM_WORDS);

   logic [cpu_pkg::WORD_W-1:0] dmem [DMEM_WORDS];
   logic [DA_W-1:0]            addr;
   logic [cpu_pkg::WORD_W-1:0] rdata;
   logic                       do_store;
   cpu_pkg::mem_wb_t           mem_wb;

   // word addressed, upper address bits ignored
   assign addr     = ex_mem.alu_result[DA_W-1:0];
   assign rdata    = dmem[addr];
   assign do_store = ex_mem.valid && ex_mem.ctrl.mem_wr && !halted;

   always_ff @(posedge clk) begin
      if (do_store) begin
         dmem[addr] <= ex_mem.store_data;
         st_addr    <= ex_mem.alu_result;
         st_data    <= ex_mem.store_data;
      end
   end

   // loads never forward from here, decode stalls that case
   assign res.mem_we   = ex_mem.valid && ex_mem.ctrl.reg_we && !ex_mem.ctrl.mem_rd;
   assign res.mem_dst  = ex_mem.dst;
   assign res.mem_data = ex_mem.alu_result;

   assign res.wb_we   = mem_wb.valid && mem_wb.reg_we;
   assign res.wb_dst  = mem_wb.dst;
   assign res.wb_data = mem_wb.wb_data;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         st_valid <= 1'b0;
         halted   <= 1'b0;
         mem_wb   <= '0;
      end else begin
         st_valid <= do_store;
         if (ex_mem.valid && ex_mem.ctrl.is_halt) halted <= 1'b1;
         if (!halted) begin
            mem_wb.valid   <= ex_mem.valid;
            mem_wb.reg_we  <= ex_mem.ctrl.reg_we;
            mem_wb.dst     <= ex_mem.dst;
            mem_wb.wb_data <= ex_mem.ctrl.mem_rd ? rdata : ex_mem.alu_result;
         end
      end
   end

endmodule

//--- tb/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

localparam int IMEM_WORDS = 256;
localparam int DMEM_WORDS = 256;
localparam int STEP_MAX   = 4000;

// program image, shared by the loader and the model
logic [15:0] prog [IMEM_WORDS];
int          prog_len;

// expected results, filled by run_model
logic [15:0] exp_regs [8];
logic [31:0] exp_stores [$];
logic        exp_err;

function automatic logic [15:0] enc_rrr(input logic [3:0] op, input int rd, input int rs,
                                        input int rt);
   return {op, 3'(rd), 3'(rs), 3'(rt), 3'b000};
endfunction

function automatic logic [15:0] enc_imm(input logic [3:0] op, input int rd, input int rs,
                                        input int imm);
   return {op, 3'(rd), 3'(rs), 6'(imm)};
endfunction

function automatic logic [15:0] enc_lbi(input int rd, input int imm);
   return {cpu_pkg::OP_LBI, 3'(rd), 9'(imm)};
endfunction

function automatic void append_instr(input logic [15:0] word);
   prog[prog_len] = word;
   prog_len++;
endfunction

// instruction-level interpreter, returns the executed count or -1
function automatic int run_model();
   logic [15:0] regs [8];
   logic [15:0] dmem [DMEM_WORDS];
   logic [15:0] pc;
   logic [15:0] ir;
   logic [15:0] a;
   logic [15:0] b;
   logic [15:0] imm6;
   logic [15:0] addr;
   logic [2:0]  rd;
   for (int r = 0; r < 8; r++) begin
      regs[r] = '0;
   end
   exp_stores.delete();
   exp_err = 1'b0;
   pc      = '0;
   for (int step = 0; step < STEP_MAX; step++) begin
      ir   = prog[pc % IMEM_WORDS];
      rd   = ir[11:9];
      a    = regs[ir[8:6]];
      b    = regs[ir[5:3]];
      imm6 = {{10{ir[5]}}, ir[5:0]};
      addr = a + imm6;
      pc   = pc + 16'd1;
      case (ir[15:12])
         cpu_pkg::OP_HALT: begin
            for (int r = 0; r < 8; r++) begin
               exp_regs[r] = regs[r];
            end
            return step + 1;
         end
         cpu_pkg::OP_NOP: ;
         cpu_pkg::OP_ADD:  regs[rd] = a + b;
         cpu_pkg::OP_SUB:  regs[rd] = a - b;
         cpu_pkg::OP_AND:  regs[rd] = a & b;
         cpu_pkg::OP_XOR:  regs[rd] = a ^ b;
         cpu_pkg::OP_ADDI: regs[rd] = addr;
         cpu_pkg::OP_LBI:  regs[rd] = {{7{ir[8]}}, ir[8:0]};
         cpu_pkg::OP_LD:   regs[rd] = dmem[addr % DMEM_WORDS];
         cpu_pkg::OP_ST: begin
            dmem[addr % DMEM_WORDS] = regs[rd];
            exp_stores.push_back({addr, regs[rd]});
         end
         cpu_pkg::OP_BEQZ: begin
            if (a == 16'd0) pc = pc + imm6;
         end
         // illegal codes behave as a nop
         default: exp_err = 1'b1;
      endcase
      // r0 reads zero whatever was written
      regs[0] = '0;
   end
   return -1;
endfunction

function automatic void gen_arith();
   prog_len = 0;
   append_instr(enc_lbi(1, 5));
   append_instr(enc_lbi(2, -3));
   append_instr(enc_rrr(cpu_pkg::OP_ADD, 3, 1, 2));
   append_instr(enc_rrr(cpu_pkg::OP_SUB, 4, 3, 1));
   append_instr(enc_rrr(cpu_pkg::OP_AND, 5, 4, 3));
   append_instr(enc_rrr(cpu_pkg::OP_XOR, 6, 5, 4));
   append_instr(enc_imm(cpu_pkg::OP_ADDI, 7, 6, -7));
   append_instr(enc_rrr(cpu_pkg::OP_ADD, 1, 7, 7));
   append_instr(enc_lbi(2, 255));
   append_instr(enc_rrr(cpu_pkg::OP_XOR, 3, 2, 1));
   append_instr(enc_rrr(cpu_pkg::OP_SUB, 0, 3, 2));
   append_instr(enc_imm(cpu_pkg::OP_HALT, 0, 0, 0));
endfunction

function automatic void gen_load_use();
   prog_len = 0;
   append_instr(enc_lbi(1, 77));
   append_instr(enc_lbi(2, 10));
   append_instr(enc_imm(cpu_pkg::OP_ST, 1, 2, 3));
   append_instr(enc_imm(cpu_pkg::OP_LD, 3, 2, 3));
   append_instr(enc_rrr(cpu_pkg::OP_ADD, 4, 3, 3));
   append_instr(enc_imm(cpu_pkg::OP_LD, 5, 0, 13));
   append_instr(enc_imm(cpu_pkg::OP_ST, 5, 0, 20));
   append_instr(enc_imm(cpu_pkg::OP_ADDI, 6, 5, 1));
   append_instr(enc_imm(cpu_pkg::OP_LD, 7, 0, 20));
   append_instr(enc_imm(cpu_pkg::OP_ST, 7, 6, -2));
   append_instr(enc_imm(cpu_pkg::OP_HALT, 0, 0, 0));
endfunction

function automatic void gen_branch();
   prog_len = 0;
   append_instr(enc_lbi(1, 4));
   append_instr(enc_lbi(2, 0));
   // loop body at 2, counts r1 down to zero
   append_instr(enc_rrr(cpu_pkg::OP_ADD, 2, 2, 1));
   append_instr(enc_imm(cpu_pkg::OP_ADDI, 1, 1, -1));
   append_instr(enc_imm(cpu_pkg::OP_BEQZ, 0, 1, 2));
   append_instr(enc_imm(cpu_pkg::OP_BEQZ, 0, 0, -4));
   append_instr(enc_lbi(3, 99));
   append_instr(enc_imm(cpu_pkg::OP_BEQZ, 0, 4, 1));
   append_instr(enc_lbi(5, 55));
   append_instr(enc_lbi(6, 3));
   append_instr(enc_imm(cpu_pkg::OP_BEQZ, 0, 6, 2));
   append_instr(enc_imm(cpu_pkg::OP_ADDI, 7, 6, 4));
   append_instr(enc_imm(cpu_pkg::OP_HALT, 0, 0, 0));
   append_instr(enc_lbi(3, 1));
endfunction

function automatic void gen_illegal();
   prog_len = 0;
   append_instr(enc_lbi(1, 9));
   append_instr(16'hb2c5);
   append_instr(enc_imm(cpu_pkg::OP_ADDI, 2, 1, 1));
   append_instr(16'hf049);
   append_instr(enc_rrr(cpu_pkg::OP_ADD, 3, 2, 1));
   append_instr(enc_imm(cpu_pkg::OP_HALT, 0, 0, 0));
endfunction

// straight line, loads only from the words 0..7 set up first
function automatic void gen_random();
   int kind;
   prog_len = 0;
   for (int k = 0; k < 8; k++) begin
      append_instr(enc_lbi(1, $urandom_range(511, 0)));
      append_instr(enc_imm(cpu_pkg::OP_ST, 1, 0, k));
   end
   for (int i = 0; i < 24; i++) begin
      kind = $urandom_range(8, 0);
      case (kind)
         0: append_instr(enc_rrr(cpu_pkg::OP_ADD, $urandom_range(7, 0),
                                 $urandom_range(7, 0), $urandom_range(7, 0)));
         1: append_instr(enc_rrr(cpu_pkg::OP_SUB, $urandom_range(7, 0),
                                 $urandom_range(7, 0), $urandom_range(7, 0)));
         2: append_instr(enc_rrr(cpu_pkg::OP_AND, $urandom_range(7, 0),
                                 $urandom_range(7, 0), $urandom_range(7, 0)));
         3: append_instr(enc_rrr(cpu_pkg::OP_XOR, $urandom_range(7, 0),
                                 $urandom_range(7, 0), $urandom_range(7, 0)));
         4: append_instr(enc_imm(cpu_pkg::OP_ADDI, $urandom_range(7, 0),
                                 $urandom_range(7, 0), $urandom_range(63, 0)));
         5: append_instr(enc_lbi($urandom_range(7, 0), $urandom_range(511, 0)));
         6: append_instr(enc_imm(cpu_pkg::OP_LD, $urandom_range(7, 0), 0,
                                 $urandom_range(7, 0)));
         7: append_instr(enc_imm(cpu_pkg::OP_ST, $urandom_range(7, 0),
                                 $urandom_range(7, 0), $urandom_range(63, 0)));
         default: append_instr(enc_imm(cpu_pkg::OP_NOP, 0, 0, 0));
      endcase
   end
   append_instr(enc_imm(cpu_pkg::OP_HALT, 0, 0, 0));
endfunction

`endif

//--- tb/cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb;

   `include "cpu_model.svh"

   localparam int HALT_TIMEOUT = 2000;
   localparam int CHECK_TIMEOUT = 40;

   logic        clk;
   logic        arst_n;
   logic        imem_we;
   logic [7:0]  imem_addr;
   logic [15:0] imem_wdata;
   logic [2:0]  dbg_addr;
   logic [15:0] dbg_data;
   logic        st_valid;
   logic [15:0] st_addr;
   logic [15:0] st_data;
   logic        halted;
   logic        err;

   logic [31:0] got_stores [$];
   string       cur_name;
   int          cur_errors;
   logic        check_req;
   int          pass_count;
   int          fail_count;

   cpu_top #(
      .IMEM_WORDS (IMEM_WORDS),
      .DMEM_WORDS (DMEM_WORDS)
   ) dut_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .imem_we    (imem_we),
      .imem_addr  (imem_addr),
      .imem_wdata (imem_wdata),
      .dbg_addr   (dbg_addr),
      .dbg_data   (dbg_data),
      .st_valid   (st_valid),
      .st_addr    (st_addr),
      .st_data    (st_data),
      .halted     (halted),
      .err        (err)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // store strobe is a full cycle wide, so one falling edge sees it
   always @(negedge clk) begin
      if (arst_n && st_valid) begin
         got_stores.push_back({st_addr, st_data});
      end
   end

   task automatic compare_results();
      for (int r = 0; r < 8; r++) begin
         @(negedge clk);
         dbg_addr = 3'(r);
         @(posedge clk);
         assert (dbg_data === exp_regs[r]) else begin
            $display("** Error %s: r%0d expected %h, actual %h",
                     cur_name, r, exp_regs[r], dbg_data);
            cur_errors++;
         end
      end
      assert (err === exp_err) else begin
         $display("** Error %s: err expected %b, actual %b", cur_name, exp_err, err);
         cur_errors++;
      end
      assert (got_stores.size() == exp_stores.size()) else begin
         $display("** Error %s: store count expected %0d, actual %0d",
                  cur_name, exp_stores.size(), got_stores.size());
         cur_errors++;
      end
      for (int i = 0; i < exp_stores.size() && i < got_stores.size(); i++) begin
         assert (got_stores[i] === exp_stores[i]) else begin
            $display("** Error %s: store %0d expected %h, actual %h",
                     cur_name, i, exp_stores[i], got_stores[i]);
            cur_errors++;
         end
      end
   endtask

   // comparison process, started by check_req
   initial begin
      forever begin
         @(negedge clk);
         if (check_req) begin
            compare_results();
            check_req = 1'b0;
         end
      end
   end

   task automatic run_test(input string name);
      int steps;
      int n;
      cur_name   = name;
      cur_errors = 0;
      steps = run_model();
      if (steps < 0) begin
         $display("%s: reference model never reached halt", name);
         cur_errors++;
      end
      @(negedge clk);
      arst_n = 1'b0;
      got_stores.delete();
      for (int i = 0; i < prog_len; i++) begin
         @(negedge clk);
         imem_we    = 1'b1;
         imem_addr  = 8'(i);
         imem_wdata = prog[i];
      end
      @(negedge clk);
      imem_we = 1'b0;
      repeat (5) @(negedge clk);
      assert ({halted, err, st_valid} === 3'b000) else begin
         $display("** Error %s: in reset expected 000, actual %b",
                  name, {halted, err, st_valid});
         cur_errors++;
      end
      arst_n = 1'b1;
      @(negedge clk);
      assert ({halted, err, st_valid} === 3'b000) else begin
         $display("** Error %s: after reset expected 000, actual %b",
                  name, {halted, err, st_valid});
         cur_errors++;
      end
      n = 0;
      while (halted !== 1'b1 && n < HALT_TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (halted !== 1'b1) begin
         $display("%s: the core did not halt within %0d cycles", name, HALT_TIMEOUT);
         cur_errors++;
      end else begin
         check_req = 1'b1;
         n = 0;
         while (check_req && n < CHECK_TIMEOUT) begin
            @(negedge clk);
            n++;
         end
         if (check_req) begin
            $display("%s: result comparison did not finish in time", name);
            cur_errors++;
         end
      end
      if (cur_errors == 0) begin
         pass_count++;
         $display("test %-12s ok", name);
      end else begin
         fail_count++;
         $display("test %-12s FAILED, %0d errors", name, cur_errors);
      end
   endtask

   initial begin
      arst_n     = 1'b0;
      imem_we    = 1'b0;
      imem_addr  = '0;
      imem_wdata = '0;
      dbg_addr   = '0;
      check_req  = 1'b0;
      pass_count = 0;
      fail_count = 0;
      void'($urandom(32'he533_3e50));
      gen_arith();
      run_test("arith_chain");
      gen_load_use();
      run_test("load_use");
      gen_branch();
      run_test("branches");
      gen_illegal();
      run_test("illegal_op");
      for (int t = 0; t < 20; t++) begin
         gen_random();
         run_test($sformatf("random_%0d", t));
      end
      $display("tests %0d, ok %0d, failing %0d", pass_count + fail_count,
               pass_count, fail_count);
      if (fail_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule
